// ==== capture/pixel_packer.sv ====
`default_nettype none

module pixel_packer (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        sensor_ready,
    input  wire                        cam_vsync,
    input  wire                        cam_href,
    input  wire  [cam_pkg::BYTE_W-1:0] cam_data,
    output logic                       pix_wr,
    output logic [cam_pkg::PIX_W-1:0]  pix_data
);

    cam_pkg::pack_phase_t          phase;
    logic [cam_pkg::BYTE_W-1:0]    hi_byte;     // r5 g3 of the current pixel
    logic                          vsync_d;
    logic                          vsync_rise;
    logic                          byte_vld;

    assign vsync_rise = cam_vsync & ~vsync_d;
    assign byte_vld   = sensor_ready & cam_href;

    // ====================
    // control
    // ====================
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            phase   <= cam_pkg::PHASE_HIGH;
            vsync_d <= 1'b0;
            pix_wr  <= 1'b0;
        end
        else
        begin
            vsync_d <= cam_vsync;
            pix_wr  <= 1'b0;
            if (sensor_ready && vsync_rise)
                phase <= cam_pkg::PHASE_HIGH;   // frame start drops a half pixel
            else if (byte_vld)
            begin
                if (phase == cam_pkg::PHASE_HIGH)
                    phase <= cam_pkg::PHASE_LOW;
                else
                begin
                    phase  <= cam_pkg::PHASE_HIGH;
                    pix_wr <= 1'b1;             // pixel complete
                end
            end
        end
    end

    // ====================
    // data path
    // ====================
    always_ff @(posedge clk)
    begin
        if (byte_vld && !vsync_rise)
        begin
            if (phase == cam_pkg::PHASE_HIGH)
                hi_byte <= cam_data;
            else
                pix_data <= {hi_byte, cam_data};
        end
    end

    // two bytes per pixel, so a write never follows a write
    a_no_back_to_back: assert property (@(posedge clk) disable iff (!rst_n)
        pix_wr |=> !pix_wr);

endmodule

`default_nettype wire

// ==== capture/sensor_power_seq.sv ====
`default_nettype none

module sensor_power_seq (
    input  wire  clk,
    input  wire  rst_n,
    output logic sensor_rst_n,
    output logic sensor_ready
);

    cam_pkg::seq_state_t              state;
    logic [cam_pkg::SEQ_CNT_W-1:0]    cnt;
    logic [cam_pkg::SEQ_CNT_W-1:0]    cnt_next;

    assign cnt_next = cnt + 1'b1;               // count this edge included

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state        <= cam_pkg::SEQ_HOLD;
            cnt          <= '0;
            sensor_rst_n <= 1'b0;
            sensor_ready <= 1'b0;
        end
        else
        begin
            if (state != cam_pkg::SEQ_READY)
                cnt <= cnt_next;                // frozen once ready
            case (state)
                cam_pkg::SEQ_HOLD:
                begin
                    if (cnt_next == cam_pkg::SEQ_RELEASE_CYCLES)
                    begin
                        state        <= cam_pkg::SEQ_WAIT;
                        sensor_rst_n <= 1'b1;
                    end
                end
                cam_pkg::SEQ_WAIT:
                begin
                    if (cnt_next == cam_pkg::SEQ_READY_CYCLES)
                    begin
                        state        <= cam_pkg::SEQ_READY;
                        sensor_ready <= 1'b1;
                    end
                end
                default: state <= cam_pkg::SEQ_READY; // hold until reset
            endcase
        end
    end

    // ready may only rise after the sensor has already left reset
    a_ready_after_release: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(sensor_ready) |-> $past(sensor_rst_n));

endmodule

`default_nettype wire

// ==== common/cam_pkg.sv ====
`default_nettype none

package cam_pkg;

    // ====================
    // data widths
    // ====================
    localparam int PIX_W  = 16;                 // packed rgb565 pixel
    localparam int BYTE_W = 8;                  // camera data bus
    localparam int CHAN_W = 8;                  // one output colour channel

    // ====================
    // pixel fifo
    // ====================
    localparam int FIFO_DEPTH = 64;
    localparam int FIFO_AW    = 6;

    // ====================
    // raster test mode
    // ====================
    localparam int H_ACTIVE = 16;               // clocks
    localparam int H_FP     = 4;
    localparam int H_SYNC   = 4;
    localparam int H_BP     = 16;
    localparam int H_TOTAL  = H_ACTIVE + H_FP + H_SYNC + H_BP; // 40 clocks per line

    localparam int V_ACTIVE = 4;                // lines
    localparam int V_FP     = 1;
    localparam int V_SYNC   = 1;
    localparam int V_BP     = 2;
    localparam int V_TOTAL  = V_ACTIVE + V_FP + V_SYNC + V_BP; // 8 lines per frame

    localparam int CNT_W = 8;                   // raster counter width

    // ====================
    // sensor power-up
    // ====================
    localparam int SEQ_RELEASE_CYCLES = 20;     // clocks until sensor reset release
    localparam int SEQ_READY_CYCLES   = 40;     // clocks until sensor ready
    localparam int SEQ_CNT_W          = 8;

    typedef enum logic [1:0] {
        SEQ_HOLD,                               // sensor held in reset
        SEQ_WAIT,                               // reset released, settling
        SEQ_READY
    } seq_state_t;

    typedef enum logic {
        PHASE_HIGH,                             // next byte is r5 g3
        PHASE_LOW                               // next byte is g3 b5
    } pack_phase_t;

    typedef enum logic {
        RASTER_IDLE,                            // waiting for fifo fill threshold
        RASTER_RUN
    } raster_state_t;

endpackage

`default_nettype wire

// ==== display/raster_gen.sv ====
`default_nettype none

module raster_gen (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire  [cam_pkg::FIFO_AW:0]    level,
    output logic                         rd_en,
    input  wire  [cam_pkg::PIX_W-1:0]    rd_data,
    output logic                         vid_hs,
    output logic                         vid_vs,
    output logic                         vid_de,
    output logic [cam_pkg::CHAN_W-1:0]   vid_r,
    output logic [cam_pkg::CHAN_W-1:0]   vid_g,
    output logic [cam_pkg::CHAN_W-1:0]   vid_b
);

    localparam int HS_START = cam_pkg::H_ACTIVE + cam_pkg::H_FP;
    localparam int HS_END   = HS_START + cam_pkg::H_SYNC;
    localparam int VS_START = cam_pkg::V_ACTIVE + cam_pkg::V_FP;
    localparam int VS_END   = VS_START + cam_pkg::V_SYNC;

    cam_pkg::raster_state_t        state;
    logic [cam_pkg::CNT_W-1:0]     h_cnt;
    logic [cam_pkg::CNT_W-1:0]     v_cnt;
    logic                          run;
    logic                          hs_int;
    logic                          vs_int;
    logic                          de_int;

    // ====================
    // timing counters
    // ====================
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= cam_pkg::RASTER_IDLE;
            h_cnt <= '0;
            v_cnt <= '0;
        end
        else if (state == cam_pkg::RASTER_IDLE)
        begin
            if (level >= cam_pkg::H_ACTIVE)
                state <= cam_pkg::RASTER_RUN;   // one line buffered, free run from here
        end
        else if (h_cnt == cam_pkg::H_TOTAL - 1)
        begin
            h_cnt <= '0;
            if (v_cnt == cam_pkg::V_TOTAL - 1)
                v_cnt <= '0;
            else
                v_cnt <= v_cnt + 1'b1;
        end
        else
            h_cnt <= h_cnt + 1'b1;
    end

    assign run    = (state == cam_pkg::RASTER_RUN);
    assign hs_int = run && (h_cnt >= HS_START) && (h_cnt < HS_END);
    assign vs_int = run && (v_cnt >= VS_START) && (v_cnt < VS_END);
    assign de_int = run && (h_cnt < cam_pkg::H_ACTIVE) && (v_cnt < cam_pkg::V_ACTIVE);
    assign rd_en  = de_int;                     // read even when empty

    // align controls with registered fifo data
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            vid_hs <= 1'b0;
            vid_vs <= 1'b0;
            vid_de <= 1'b0;
        end
        else
        begin
            vid_hs <= hs_int;
            vid_vs <= vs_int;
            vid_de <= de_int;
        end
    end

    // ====================
    // rgb565 to rgb888
    // ====================
    assign vid_r = vid_de ? {rd_data[15:11], {(cam_pkg::CHAN_W - 5){1'b0}}} : '0;
    assign vid_g = vid_de ? {rd_data[10:5], {(cam_pkg::CHAN_W - 6){1'b0}}} : '0;
    assign vid_b = vid_de ? {rd_data[4:0], {(cam_pkg::CHAN_W - 5){1'b0}}} : '0;

    a_de_outside_sync: assert property (@(posedge clk) disable iff (!rst_n)
        vid_de |-> !(vid_hs || vid_vs));

endmodule

`default_nettype wire

// ==== project.f ====
common/cam_pkg.sv
capture/sensor_power_seq.sv
capture/pixel_packer.sv
verilog/pixel_fifo.sv
display/raster_gen.sv
verilog/cam_display_top.sv
verification/tb_clock_gen.sv
verification/cam_display_tb.sv

// ==== verification/cam_display_tb.sv ====
`default_nettype none

module cam_display_tb;

    localparam int FRAME_CLKS = cam_pkg::H_TOTAL * cam_pkg::V_TOTAL;

    logic                          clk;
    logic                          rst_n;
    logic                          rst_req;
    logic                          cam_vsync;
    logic                          cam_href;
    logic [cam_pkg::BYTE_W-1:0]    cam_data;
    logic                          sensor_rst_n;
    logic                          sensor_ready;
    logic                          vid_hs;
    logic                          vid_vs;
    logic                          vid_de;
    logic [cam_pkg::CHAN_W-1:0]    vid_r;
    logic [cam_pkg::CHAN_W-1:0]    vid_g;
    logic [cam_pkg::CHAN_W-1:0]    vid_b;
    logic                          fifo_overflow;
    logic                          fifo_underflow;

    logic [cam_pkg::PIX_W-1:0]     exp_q[$];    // pixels sent and not yet shown
    logic [cam_pkg::PIX_W-1:0]     exp_pix;
    bit                            pix_mon_en = 1'b1;
    bit                            sync_mon_en = 1'b1;
    bit                            hs_prev = 1'b0;
    bit                            vs_prev = 1'b0;
    int                            blank_de = 0;
    int                            cyc = 0;
    int                            last_hs = -1;
    int                            last_vs = -1;
    int                            lines_seen = 0;
    int                            frames_seen = 0;
    int                            value_errs = 0;
    int                            other_errs = 0;

    tb_clock_gen tb_clock_gen_i (
        .rst_req (rst_req),
        .clk     (clk),
        .rst_n   (rst_n)
    );

    cam_display_top cam_display_top_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .cam_vsync      (cam_vsync),
        .cam_href       (cam_href),
        .cam_data       (cam_data),
        .sensor_rst_n   (sensor_rst_n),
        .sensor_ready   (sensor_ready),
        .vid_hs         (vid_hs),
        .vid_vs         (vid_vs),
        .vid_de         (vid_de),
        .vid_r          (vid_r),
        .vid_g          (vid_g),
        .vid_b          (vid_b),
        .fifo_overflow  (fifo_overflow),
        .fifo_underflow (fifo_underflow)
    );

    // ====================
    // helpers
    // ====================
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual)
        else
        begin
            $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
            value_errs++;
        end
    endtask

    task automatic report_problem(input string what);
        $display("Error: %s", what);
        other_errs++;
    endtask

    task automatic check_reset_outputs();
        check_value("reset_state", 0, {sensor_rst_n, sensor_ready, vid_de, vid_hs,
                                       vid_vs, fifo_overflow, fifo_underflow});
    endtask

    task automatic send_byte(input logic [cam_pkg::BYTE_W-1:0] b);
        @(negedge clk);
        cam_href = 1'b1;
        cam_data = b;
    endtask

    task automatic send_pixel(input logic [cam_pkg::PIX_W-1:0] pix, input bit track);
        send_byte(pix[15:8]);                   // high byte first
        send_byte(pix[7:0]);
        if (track)
            exp_q.push_back(pix);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(negedge clk);
            cam_href = 1'b0;
        end
    endtask

    task automatic pulse_vsync();
        @(negedge clk);
        cam_href  = 1'b0;
        cam_vsync = 1'b1;
        @(negedge clk);
        cam_vsync = 1'b0;
    endtask

    // ====================
    // monitors
    // ====================
    always @(negedge clk)
    begin
        if (pix_mon_en && vid_de && exp_q.size() > 0)
        begin
            exp_pix = exp_q.pop_front();
            check_value("pixel_r", {exp_pix[15:11], 3'b000}, vid_r);
            check_value("pixel_g", {exp_pix[10:5], 2'b00}, vid_g);
            check_value("pixel_b", {exp_pix[4:0], 3'b000}, vid_b);
            check_value("underflow_early", 0, fifo_underflow);
        end
        else if (pix_mon_en && vid_de)
        begin
            check_value("blank_rgb", 0, {vid_r, vid_g, vid_b});   // underflow shows black
            blank_de++;
        end
        else if (pix_mon_en)
            check_value("rgb_outside_de", 0, {vid_r, vid_g, vid_b});
    end

    always @(negedge clk)
    begin
        cyc++;
        if (!sync_mon_en)
        begin
            hs_prev = 1'b0;
            vs_prev = 1'b0;
            last_hs = -1;
            last_vs = -1;
        end
        else
        begin
            check_value("de_during_sync", 0, vid_de && (vid_hs || vid_vs));
            if (vid_hs && !hs_prev)
            begin
                if (last_hs >= 0)
                begin
                    check_value("line_length", cam_pkg::H_TOTAL, cyc - last_hs);
                    lines_seen++;
                end
                last_hs = cyc;
            end
            if (vid_vs && !vs_prev)
            begin
                if (last_vs >= 0)
                begin
                    check_value("frame_length", FRAME_CLKS, cyc - last_vs);
                    frames_seen++;
                end
                last_vs = cyc;
            end
            hs_prev = vid_hs;
            vs_prev = vid_vs;
        end
    end

    // ====================
    // stimulus
    // ====================
    initial
    begin : main_seq
        int          n;
        int          edge_cnt;
        int          clks;
        logic [31:0] rnd;
        bit          ovf_seen;

        void'($urandom(32'h7d51ecf0));
        rst_req   = 1'b0;
        cam_vsync = 1'b0;
        cam_href  = 1'b0;
        cam_data  = '0;

        n = 0;
        @(posedge clk);
        while (!rst_n && n < 64)
        begin
            check_reset_outputs();
            @(posedge clk);
            n++;
        end
        if (!rst_n)
            report_problem("the initial reset was never released.");
        edge_cnt = 1;                           // first edge with rst_n high
        while (edge_cnt <= cam_pkg::SEQ_READY_CYCLES + 4)
        begin
            @(negedge clk);
            if (edge_cnt == 1)
                check_reset_outputs();
            check_value("sensor_rst_n", edge_cnt >= cam_pkg::SEQ_RELEASE_CYCLES,
                        sensor_rst_n);
            check_value("sensor_ready", edge_cnt >= cam_pkg::SEQ_READY_CYCLES,
                        sensor_ready);
            edge_cnt++;
        end

        // pixel order with an odd byte dropped by vsync
        pulse_vsync();
        rnd = $urandom();
        send_byte(rnd[7:0]);
        idle_cycles(2);
        pulse_vsync();
        idle_cycles(2);
        for (int line = 0; line < 3; line++)
        begin
            for (int px = 0; px < cam_pkg::H_ACTIVE; px++)
            begin
                rnd = $urandom();
                send_pixel(rnd[15:0], 1'b1);
            end
            idle_cycles(2);                     // short horizontal blank
        end
        n = 0;
        while (exp_q.size() != 0 && n < 4 * FRAME_CLKS)
        begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0)
            report_problem("not all sent pixels reached the display.");
        check_value("no_overflow", 0, fifo_overflow);

        // underflow once the pixels run out
        n = 0;
        while (!fifo_underflow && n < 2 * FRAME_CLKS)
        begin
            @(negedge clk);
            n++;
        end
        if (!fifo_underflow)
            report_problem("fifo_underflow never rose after the FIFO ran empty.");
        repeat (2 * FRAME_CLKS)
        begin
            @(negedge clk);
            check_value("underflow_sticky", 1, fifo_underflow);
        end
        if (blank_de < cam_pkg::H_ACTIVE)
            report_problem("too few blank data-enable cycles were seen after underflow.");

        // overflow under a continuous stream
        pix_mon_en  = 1'b0;
        sync_mon_en = 1'b0;
        @(negedge clk);
        rst_req = 1'b1;
        @(negedge clk);
        rst_req = 1'b0;
        n = 0;
        @(posedge clk);
        while (!rst_n && n < 64)
        begin
            @(posedge clk);
            n++;
        end
        @(negedge clk);
        check_value("underflow_reset", 0, fifo_underflow);
        sync_mon_en = 1'b1;
        n = 0;
        while (!sensor_ready && n < 2 * cam_pkg::SEQ_READY_CYCLES)
        begin
            @(negedge clk);
            n++;
        end
        if (!sensor_ready)
            report_problem("sensor_ready did not rise after the second reset.");
        ovf_seen = 1'b0;
        clks     = 0;
        for (int i = 0; i < 600; i++)
        begin
            rnd = $urandom();
            send_pixel(rnd[15:0], 1'b0);
            clks += 2;
            if (fifo_overflow)
                ovf_seen = 1'b1;
        end
        idle_cycles(1);
        while (!ovf_seen && clks < 3000)
        begin
            @(negedge clk);
            clks++;
            ovf_seen = fifo_overflow;
        end
        if (!ovf_seen)
            report_problem("fifo_overflow did not rise within 3000 clocks.");
        idle_cycles(FRAME_CLKS);
        check_value("overflow_sticky", 1, fifo_overflow);
        if (lines_seen == 0)
            report_problem("no complete video line was measured.");
        if (frames_seen == 0)
            report_problem("no complete video frame was measured.");

        $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
    input  wire  rst_req,
    output logic clk,
    output logic rst_n
);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;                 // period 20
    end

    // reset at start and again on each request
    always
    begin
        rst_n = 1'b0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(posedge rst_req);
    end

endmodule

`default_nettype wire

// ==== verilog/cam_display_top.sv ====
`default_nettype none

module cam_display_top (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          cam_vsync,
    input  wire                          cam_href,
    input  wire  [cam_pkg::BYTE_W-1:0]   cam_data,
    output logic                         sensor_rst_n,
    output logic                         sensor_ready,
    output logic                         vid_hs,
    output logic                         vid_vs,
    output logic                         vid_de,
    output logic [cam_pkg::CHAN_W-1:0]   vid_r,
    output logic [cam_pkg::CHAN_W-1:0]   vid_g,
    output logic [cam_pkg::CHAN_W-1:0]   vid_b,
    output logic                         fifo_overflow,
    output logic                         fifo_underflow
);

    logic                          pix_wr;
    logic [cam_pkg::PIX_W-1:0]     pix_data;
    logic                          rd_en;
    logic [cam_pkg::PIX_W-1:0]     rd_data;
    logic [cam_pkg::FIFO_AW:0]     level;

    sensor_power_seq sensor_power_seq_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .sensor_rst_n (sensor_rst_n),
        .sensor_ready (sensor_ready)
    );

    pixel_packer pixel_packer_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .sensor_ready (sensor_ready),
        .cam_vsync    (cam_vsync),
        .cam_href     (cam_href),
        .cam_data     (cam_data),
        .pix_wr       (pix_wr),
        .pix_data     (pix_data)
    );

    // stands in for the frame buffer
    pixel_fifo pixel_fifo_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .wr_en          (pix_wr),
        .wr_data        (pix_data),
        .rd_en          (rd_en),
        .rd_data        (rd_data),
        .empty          (),                     // raster reads on level only
        .level          (level),
        .fifo_overflow  (fifo_overflow),
        .fifo_underflow (fifo_underflow)
    );

    raster_gen raster_gen_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .level   (level),
        .rd_en   (rd_en),
        .rd_data (rd_data),
        .vid_hs  (vid_hs),
        .vid_vs  (vid_vs),
        .vid_de  (vid_de),
        .vid_r   (vid_r),
        .vid_g   (vid_g),
        .vid_b   (vid_b)
    );

endmodule

`default_nettype wire

// ==== verilog/pixel_fifo.sv ====
`default_nettype none

module pixel_fifo (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         wr_en,
    input  wire  [cam_pkg::PIX_W-1:0]   wr_data,
    input  wire                         rd_en,
    output logic [cam_pkg::PIX_W-1:0]   rd_data,
    output logic                        empty,
    output logic [cam_pkg::FIFO_AW:0]   level,
    output logic                        fifo_overflow,
    output logic                        fifo_underflow
);

    logic [cam_pkg::PIX_W-1:0]  mem [cam_pkg::FIFO_DEPTH];
    logic [cam_pkg::FIFO_AW:0]  wr_ptr;         // extra msb tells wrap
    logic [cam_pkg::FIFO_AW:0]  rd_ptr;
    logic                       full;
    logic                       do_wr;
    logic                       do_rd;

    assign level = wr_ptr - rd_ptr;
    assign empty = (level == 0);
    assign full  = (level == cam_pkg::FIFO_DEPTH);
    assign do_wr = wr_en & ~full;
    assign do_rd = rd_en & ~empty;

    // ====================
    // pointers and flags
    // ====================
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            fifo_overflow  <= 1'b0;
            fifo_underflow <= 1'b0;
        end
        else
        begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            if (wr_en && full)
                fifo_overflow <= 1'b1;          // pixel dropped, sticky
            if (rd_en && empty)
                fifo_underflow <= 1'b1;         // sticky
        end
    end

    // ====================
    // storage
    // ====================
    always_ff @(posedge clk)
    begin
        if (do_wr)
            mem[wr_ptr[cam_pkg::FIFO_AW-1:0]] <= wr_data;
        if (do_rd)
            rd_data <= mem[rd_ptr[cam_pkg::FIFO_AW-1:0]];
        else if (rd_en)
            rd_data <= '0;                      // empty read shows black
    end

    a_level_bound: assert property (@(posedge clk) disable iff (!rst_n)
        level <= cam_pkg::FIFO_DEPTH);

endmodule

`default_nettype wire
